/* verilog.f */
hw/mipsPkg.sv
hw/decode.sv
hw/fetchControl.sv
hw/regFile.sv
hw/alu.sv
hw/memAccess.sv
hw/mipsCpu.sv
testbench/memModel.sv
testbench/mipsCpuTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the mipsCpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mipsCpuTb \
    -f verilog.f \
    -o simMips

# tee keeps the log even when the simulation stops on $fatal
./obj_dir/simMips | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

/* testbench/mipsTests.mem */
// Each test: word count, that many instruction words, expected v0
// A count of zero ends the list
// ALU and immediate forms, lui
00000006
3C081234 35085678 2409FFFF 01095023 394200FF 00000008
12345686
// slt, sltu, slti, sltiu, sll, or, and
0000000E
2408FFFB 24090007 0109502A 0109582B 2D2CFFFF 290DFFFA 000B5840
000C6080 000D68C0 014B1025 004C1025 004D1025 00491024 00000008
00000005
// Fixed and variable shifts on a negative value
0000000B
2408FF00 00084903 00085702 240B0008 01686007 01686806 016A7004
012D1026 004E1021 004C1026 00000008
00FFF0F0
// Stores then loads of bytes, halves and words
00000011
24080100 3C098182 35298384 AD090000 AD000004 810A0001 910B0003
850C0002 950D0000 A5090004 A1090007 8D0E0004 014B1021 004C1021
004D1021 004E1021 00000008
8400888E
// Branches, jumps and links with no delay slot
00000019
24080001 11000002 15000001 24027777 05010001 24027777 05000001
0FF0000A 24027777 24027777 03E01021 04110001 24027777 03E21023
3C09BFC0 35290048 01205009 24027777 01495023 004A1021 05100001
005F1021 0BF00018 24027777 00000008
BFC00060
00000000

/* testbench/mipsCpuTb.sv */
`timescale 1ns/1ns

module mipsCpuTb;
    import mipsPkg::*;

    logic clk;
    logic reset;
    logic [31:0] address;
    logic read;
    logic write;
    logic [31:0] writedata;
    logic [3:0] byteenable;
    logic [31:0] readdata;
    logic waitrequest;
    logic active;
    logic [31:0] registerV0;
    logic loadEnable;
    logic [7:0] loadIndex;
    logic [31:0] loadData;
    logic protocolError;

    logic [31:0] tests [512];
    int cycleCount;
    int cycleLimit;

    mipsCpu uut (
        .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .waitrequest(waitrequest), .active(active), .registerV0(registerV0)
    );

    memModel memory (
        .clk(clk), .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest),
        .loadEnable(loadEnable), .loadIndex(loadIndex), .loadData(loadData),
        .protocolError(protocolError)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(string what, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic stopWithError(string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) stopWithError("timeout: CPU never halted");
    end

    // Bus rules checked away from the clock edge
    always @(negedge clk) begin
        if (protocolError) stopWithError("memory request changed while waitrequest was high");
        if (!reset && !active && write) stopWithError("a write was issued after the CPU halted");
    end

    task automatic runProgram(int base, int count, logic [31:0] expected, int testNo);
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            loadEnable = 1'b1;
            loadIndex = i[7:0];
            loadData = tests[base + 1 + i];
        end
        @(negedge clk);
        loadEnable = 1'b0;
        repeat (8) @(negedge clk); // Reset held for 8 cycles
        reset = 1'b0;
        checkValue("active after reset", {31'b0, active}, 32'd1);
        @(negedge clk); // First cycle after release
        checkValue("first fetch read", {31'b0, read}, 32'd1);
        checkValue("first fetch address", address, resetVector);
        while (active) @(negedge clk);
        repeat (3) @(negedge clk);
        checkValue($sformatf("v0 of test %0d", testNo), registerV0, expected);
    endtask

    initial begin
        int ptr;
        int testNo;
        int totalWords;
        reset = 1'b1;
        loadEnable = 1'b0;
        loadIndex = '0;
        loadData = '0;
        cycleCount = 0;
        cycleLimit = 0;
        for (int i = 0; i < 512; i++) tests[i] = '0;
        $readmemh("testbench/mipsTests.mem", tests);

        ptr = 0;
        totalWords = 0;
        while (tests[ptr] != 0) begin
            totalWords += int'(tests[ptr]);
            ptr += int'(tests[ptr]) + 2;
        end
        if (totalWords == 0) stopWithError("the test file holds no programs");
        cycleLimit = 60 * totalWords;

        ptr = 0;
        testNo = 0;
        while (tests[ptr] != 0) begin
            testNo++;
            runProgram(ptr, int'(tests[ptr]), tests[ptr + int'(tests[ptr]) + 1], testNo);
            ptr += int'(tests[ptr]) + 2;
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* testbench/memModel.sv */
`timescale 1ns/1ns

module memModel (
    input logic clk,
    input logic [31:0] address,
    input logic read,
    input logic write,
    input logic [31:0] writedata,
    input logic [3:0] byteenable,
    output logic [31:0] readdata,
    output logic waitrequest,
    input logic loadEnable,
    input logic [7:0] loadIndex,
    input logic [31:0] loadData,
    output logic protocolError
);

    typedef struct packed {
        logic [31:0] address;
        logic read;
        logic write;
        logic [31:0] writedata;
        logic [3:0] byteenable;
    } request_t;

    logic [31:0] progMem [256];
    logic [31:0] dataMem [256];
    integer seed;
    logic pending;
    logic isProgram;
    request_t current;
    request_t held;

    initial begin
        seed = 32'h9708_c5a5;
        waitrequest = 1'b0;
        pending = 1'b0;
        protocolError = 1'b0;
    end

    assign current = {address, read, write, writedata, byteenable};
    assign isProgram = (address[31:20] == 12'hBFC); // Program region at the reset vector
    assign readdata = isProgram ? progMem[address[9:2]] : dataMem[address[9:2]];

    // Random stall, about one cycle in four
    always @(negedge clk) begin
        waitrequest <= (($random(seed) & 3) == 0);
    end

    always @(posedge clk) begin
        if (loadEnable) progMem[loadIndex] <= loadData;
        if (pending && current != held) protocolError <= 1'b1;
        if ((read || write) && waitrequest) begin
            pending <= 1'b1;
            held <= current;
        end else begin
            pending <= 1'b0;
        end
        if (write && !waitrequest) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteenable[lane]) begin
                    if (isProgram) progMem[address[9:2]][lane*8 +: 8] <= writedata[lane*8 +: 8];
                    else dataMem[address[9:2]][lane*8 +: 8] <= writedata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

/* hw/mipsCpu.sv */
`timescale 1ns/1ns

module mipsCpu (
    input logic clk,
    input logic reset,
    output logic [31:0] address,
    output logic read,
    output logic write,
    output logic [31:0] writedata,
    output logic [3:0] byteenable,
    input logic [31:0] readdata,
    input logic waitrequest,
    output logic active,
    output logic [31:0] registerV0
);
    import mipsPkg::*;

    control_t control;
    instrWord_u instruction;
    state_e state;
    logic memStall;
    logic branchTaken;
    logic fetchRead;
    logic halted;
    logic regWrite;
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] readDataA;
    logic [31:0] readDataB;
    logic [31:0] aluResult;
    logic [31:0] loadResult;
    logic [31:0] writeBack;

    assign active = !halted;
    assign regWrite = (state == writebackState) && control.writeReg;
    assign writeBack = isLoad(control.memOp) ? loadResult : aluResult;

    fetchControl fetchControlInst (
        .clk(clk), .reset(reset), .control(control), .memStall(memStall),
        .branchTaken(branchTaken), .nextPc(nextPc), .readdata(readdata),
        .waitrequest(waitrequest), .instruction(instruction), .pc(pc),
        .state(state), .fetchRead(fetchRead), .halted(halted)
    );

    decode decodeInst (
        .instruction(instruction), .waitrequest(waitrequest),
        .control(control), .memStall(memStall)
    );

    regFile regFileInst (
        .clk(clk), .reset(reset), .readIndexA(control.rs), .readIndexB(control.rt),
        .writeEnable(regWrite), .writeIndex(control.writeIndex), .writeData(writeBack),
        .readDataA(readDataA), .readDataB(readDataB), .registerV0(registerV0)
    );

    alu aluInst (
        .control(control), .operandA(readDataA), .operandB(readDataB), .pc(pc),
        .result(aluResult), .branchTaken(branchTaken), .nextPc(nextPc)
    );

    memAccess memAccessInst (
        .clk(clk), .reset(reset), .control(control), .state(state),
        .fetchRead(fetchRead), .pc(pc), .effectiveAddress(aluResult),
        .storeData(readDataB), .readdata(readdata), .waitrequest(waitrequest),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .loadResult(loadResult)
    );

endmodule

/* hw/memAccess.sv */
`timescale 1ns/1ns

module memAccess (
    input logic clk,
    input logic reset,
    input mipsPkg::control_t control,
    input mipsPkg::state_e state,
    input logic fetchRead,
    input logic [31:0] pc,
    input logic [31:0] effectiveAddress,
    input logic [31:0] storeData,
    input logic [31:0] readdata,
    input logic waitrequest,
    output logic [31:0] address,
    output logic read,
    output logic write,
    output logic [31:0] writedata,
    output logic [3:0] byteenable,
    output logic [31:0] loadResult
);
    import mipsPkg::*;

    logic dataPhase;
    logic [1:0] offset;
    logic [3:0] laneMask;
    logic [31:0] shifted;
    logic [31:0] loadValue;

    assign dataPhase = (state == memState);
    assign offset = effectiveAddress[1:0];
    assign read = fetchRead || (dataPhase && isLoad(control.memOp));
    assign write = dataPhase && isStore(control.memOp);
    assign address = fetchRead ? pc : {effectiveAddress[31:2], 2'b00};
    assign byteenable = fetchRead ? 4'hF : ((read || write) ? laneMask : 4'h0);

    always_comb begin
        case (control.memOp)
            memLb, memLbu, memSb: laneMask = 4'b0001 << offset; // Little-endian lanes
            memLh, memLhu, memSh: laneMask = offset[1] ? 4'b1100 : 4'b0011;
            memLw, memSw: laneMask = 4'hF;
            default: laneMask = 4'h0;
        endcase
    end

    always_comb begin
        case (control.memOp)
            memSb: writedata = {4{storeData[7:0]}};
            memSh: writedata = {2{storeData[15:0]}};
            default: writedata = storeData;
        endcase
    end

    assign shifted = readdata >> {offset, 3'b000};

    always_comb begin
        case (control.memOp)
            memLb: loadValue = {{24{shifted[7]}}, shifted[7:0]};
            memLbu: loadValue = {24'b0, shifted[7:0]};
            memLh: loadValue = {{16{shifted[15]}}, shifted[15:0]};
            memLhu: loadValue = {16'b0, shifted[15:0]};
            default: loadValue = readdata;
        endcase
    end

    // Readdata is only valid in the accepting cycle
    always_ff @(posedge clk) begin
        if (dataPhase && read && !waitrequest) loadResult <= loadValue;
    end

    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write requested together");

endmodule

/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
    input mipsPkg::control_t control,
    input logic [31:0] operandA,
    input logic [31:0] operandB,
    input logic [31:0] pc,
    output logic [31:0] result,
    output logic branchTaken,
    output logic [31:0] nextPc
);
    import mipsPkg::*;

    logic [31:0] immExtended;
    logic [31:0] b;
    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;

    assign immExtended = control.signExtend ? {{16{control.immediate[15]}}, control.immediate}
                                            : {16'b0, control.immediate};
    assign b = control.useImmediate ? immExtended : operandB;
    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{control.immediate[15]}}, control.immediate, 2'b00};

    always_comb begin
        case (control.aluOp)
            aluSub: result = operandA - b;
            aluAnd: result = operandA & b;
            aluOr: result = operandA | b;
            aluXor: result = operandA ^ b;
            aluSlt: result = {31'b0, $signed(operandA) < $signed(b)};
            aluSltu: result = {31'b0, operandA < b};
            aluSll: result = b << control.shamt;
            aluSrl: result = b >> control.shamt;
            aluSra: result = $signed(b) >>> control.shamt;
            aluSllv: result = b << operandA[4:0];
            aluSrlv: result = b >> operandA[4:0];
            aluSrav: result = $signed(b) >>> operandA[4:0];
            aluLui: result = {control.immediate, 16'b0};
            default: result = operandA + b; // Also load and store address
        endcase
        if (control.link) result = pcPlus4; // No delay slot
    end

    always_comb begin
        case (control.branchOp)
            brBeq: branchTaken = (operandA == operandB);
            brBne: branchTaken = (operandA != operandB);
            brBgez: branchTaken = !operandA[31];
            brBgtz: branchTaken = !operandA[31] && (operandA != '0);
            brBlez: branchTaken = operandA[31] || (operandA == '0);
            brBltz: branchTaken = operandA[31];
            brJ, brJr: branchTaken = 1'b1;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (control.branchOp == brJ) nextPc = {pcPlus4[31:28], control.target, 2'b00};
        else if (control.branchOp == brJr) nextPc = operandA;
        else if (branchTaken) nextPc = branchTarget;
        else nextPc = pcPlus4;
    end

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input logic clk,
    input logic reset,
    input logic [4:0] readIndexA,
    input logic [4:0] readIndexB,
    input logic writeEnable,
    input logic [4:0] writeIndex,
    input logic [31:0] writeData,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB,
    output logic [31:0] registerV0
);

    logic [31:0] registers [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            registers[writeIndex] <= writeData;
        end
    end

    assign readDataA = registers[readIndexA];
    assign readDataB = registers[readIndexB];
    assign registerV0 = registers[2]; // v0

    assert property (@(posedge clk) disable iff (reset)
        (writeEnable && writeIndex == '0) |=> (registers[0] == '0))
        else $error("register zero was written");

endmodule

/* hw/fetchControl.sv */
`timescale 1ns/1ns

module fetchControl (
    input logic clk,
    input logic reset,
    input mipsPkg::control_t control,
    input logic memStall,
    input logic branchTaken,
    input logic [31:0] nextPc,
    input logic [31:0] readdata,
    input logic waitrequest,
    output mipsPkg::instrWord_u instruction,
    output logic [31:0] pc,
    output mipsPkg::state_e state,
    output logic fetchRead,
    output logic halted
);
    import mipsPkg::*;

    logic started;
    logic fetchDone;
    logic haltJump;

    // First read goes out one cycle after reset releases
    assign fetchRead = started && !halted && (state == fetchState);
    assign fetchDone = fetchRead && !waitrequest;
    assign haltJump = branchTaken && (control.branchOp inside {brJ, brJr}) && (nextPc == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetchState;
            pc <= resetVector;
            started <= 1'b0;
            halted <= 1'b0;
        end else begin
            started <= 1'b1;
            case (state)
                fetchState: if (fetchDone) state <= executeState;
                executeState: begin
                    state <= (control.memOp != memNone) ? memState : writebackState;
                end
                memState: if (!memStall) state <= writebackState;
                writebackState: begin
                    state <= fetchState;
                    pc <= nextPc;
                    if (haltJump) halted <= 1'b1;
                end
                default: state <= fetchState;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) instruction <= readdata; // Instruction register
    end

    // A stalled fetch or data request keeps its state and PC
    assert property (@(posedge clk) disable iff (reset)
        ((fetchRead || state == memState) && waitrequest)
            |=> ($stable(state) && $stable(pc)))
        else $error("bus request moved on while waitrequest was high");

endmodule

/* hw/decode.sv */
`timescale 1ns/1ns

module decode (
    input mipsPkg::instrWord_u instruction,
    input logic waitrequest,
    output mipsPkg::control_t control,
    output logic memStall
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;

    assign opcode = instruction.rFormat.opcode;
    assign funct = instruction.rFormat.funct;
    assign rt = instruction.iFormat.rt;

    always_comb begin
        control = '0;
        control.rs = instruction.rFormat.rs;
        control.rt = rt;
        control.shamt = instruction.rFormat.shamt;
        control.immediate = instruction.iFormat.immediate;
        control.target = instruction.jFormat.target;
        control.writeIndex = rt; // I-type result goes to rt
        case (opcode)
            opSpecial: begin
                control.writeReg = 1'b1;
                control.writeIndex = instruction.rFormat.rd;
                case (funct)
                    fnAddu: control.aluOp = aluAdd;
                    fnSubu: control.aluOp = aluSub;
                    fnAnd: control.aluOp = aluAnd;
                    fnOr: control.aluOp = aluOr;
                    fnXor: control.aluOp = aluXor;
                    fnSlt: control.aluOp = aluSlt;
                    fnSltu: control.aluOp = aluSltu;
                    fnSll: control.aluOp = aluSll;
                    fnSrl: control.aluOp = aluSrl;
                    fnSra: control.aluOp = aluSra;
                    fnSllv: control.aluOp = aluSllv;
                    fnSrlv: control.aluOp = aluSrlv;
                    fnSrav: control.aluOp = aluSrav;
                    fnJr: begin
                        control.branchOp = brJr;
                        control.writeReg = 1'b0;
                    end
                    fnJalr: begin
                        control.branchOp = brJr;
                        control.link = 1'b1; // Links to rd
                    end
                    fnMult, fnMultu, fnDiv, fnDivu, fnMthi, fnMtlo: control.writeReg = 1'b0;
                    default: control.writeReg = 1'b0;
                endcase
            end
            opRegimm: begin
                case (rt)
                    rtBltz, rtBltzal: control.branchOp = brBltz;
                    rtBgez, rtBgezal: control.branchOp = brBgez;
                    default: control.branchOp = brNone;
                endcase
                if (rt == rtBltzal || rt == rtBgezal) begin
                    control.link = 1'b1;
                    control.writeReg = 1'b1;
                    control.writeIndex = linkReg;
                end
            end
            opJ: control.branchOp = brJ;
            opJal: begin
                control.branchOp = brJ;
                control.link = 1'b1;
                control.writeReg = 1'b1;
                control.writeIndex = linkReg;
            end
            opBeq: control.branchOp = brBeq;
            opBne: control.branchOp = brBne;
            opBlez: if (rt == '0) control.branchOp = brBlez;
            opBgtz: if (rt == '0) control.branchOp = brBgtz;
            opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                control.useImmediate = 1'b1;
                control.writeReg = 1'b1;
                control.signExtend = opcode inside {opAddiu, opSlti, opSltiu};
                case (opcode)
                    opSlti: control.aluOp = aluSlt;
                    opSltiu: control.aluOp = aluSltu; // Sign-extended, compared unsigned
                    opAndi: control.aluOp = aluAnd;
                    opOri: control.aluOp = aluOr;
                    opXori: control.aluOp = aluXor;
                    opLui: control.aluOp = aluLui;
                    default: control.aluOp = aluAdd;
                endcase
            end
            opLb, opLbu, opLh, opLhu, opLw, opSb, opSh, opSw: begin
                control.useImmediate = 1'b1;
                control.signExtend = 1'b1;
                case (opcode)
                    opLb: control.memOp = memLb;
                    opLbu: control.memOp = memLbu;
                    opLh: control.memOp = memLh;
                    opLhu: control.memOp = memLhu;
                    opLw: control.memOp = memLw;
                    opSb: control.memOp = memSb;
                    opSh: control.memOp = memSh;
                    default: control.memOp = memSw;
                endcase
                control.writeReg = isLoad(control.memOp);
            end
            opLwl, opLwr: control.writeReg = 1'b0; // Unaligned loads run as no-ops
            default: control.writeReg = 1'b0;
        endcase
    end

    assign memStall = (control.memOp != memNone) && waitrequest;

endmodule

/* hw/mipsPkg.sv */
package mipsPkg;

    localparam logic [31:0] resetVector = 32'hBFC0_0000;
    localparam logic [4:0] linkReg = 5'd31;

    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm = 6'b000001;
    localparam logic [5:0] opJ = 6'b000010;
    localparam logic [5:0] opJal = 6'b000011;
    localparam logic [5:0] opBeq = 6'b000100;
    localparam logic [5:0] opBne = 6'b000101;
    localparam logic [5:0] opBlez = 6'b000110;
    localparam logic [5:0] opBgtz = 6'b000111;
    localparam logic [5:0] opAddiu = 6'b001001;
    localparam logic [5:0] opSlti = 6'b001010;
    localparam logic [5:0] opSltiu = 6'b001011;
    localparam logic [5:0] opAndi = 6'b001100;
    localparam logic [5:0] opOri = 6'b001101;
    localparam logic [5:0] opXori = 6'b001110;
    localparam logic [5:0] opLui = 6'b001111;
    localparam logic [5:0] opLb = 6'b100000;
    localparam logic [5:0] opLh = 6'b100001;
    localparam logic [5:0] opLwl = 6'b100010;
    localparam logic [5:0] opLw = 6'b100011;
    localparam logic [5:0] opLbu = 6'b100100;
    localparam logic [5:0] opLhu = 6'b100101;
    localparam logic [5:0] opLwr = 6'b100110;
    localparam logic [5:0] opSb = 6'b101000;
    localparam logic [5:0] opSh = 6'b101001;
    localparam logic [5:0] opSw = 6'b101011;

    localparam logic [5:0] fnSll = 6'b000000;
    localparam logic [5:0] fnSrl = 6'b000010;
    localparam logic [5:0] fnSra = 6'b000011;
    localparam logic [5:0] fnSllv = 6'b000100;
    localparam logic [5:0] fnSrlv = 6'b000110;
    localparam logic [5:0] fnSrav = 6'b000111;
    localparam logic [5:0] fnJr = 6'b001000;
    localparam logic [5:0] fnJalr = 6'b001001;
    localparam logic [5:0] fnMthi = 6'b010001;
    localparam logic [5:0] fnMtlo = 6'b010011;
    localparam logic [5:0] fnMult = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;
    localparam logic [5:0] fnDiv = 6'b011010;
    localparam logic [5:0] fnDivu = 6'b011011;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr = 6'b100101;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnSlt = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    // REGIMM branches are selected by the rt field
    localparam logic [4:0] rtBltz = 5'b00000;
    localparam logic [4:0] rtBgez = 5'b00001;
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] immediate;
    } iFormat_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [25:0] target;
    } jFormat_t;

    typedef union packed {
        rFormat_t rFormat;
        iFormat_t iFormat;
        jFormat_t jFormat;
    } instrWord_u;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav, aluLui
    } aluOp_e;

    typedef enum logic [3:0] {
        memNone, memLb, memLbu, memLh, memLhu, memLw, memSb, memSh, memSw
    } memOp_e;

    typedef enum logic [3:0] {
        brNone, brBeq, brBne, brBgez, brBgtz, brBlez, brBltz, brJ, brJr
    } branchOp_e;

    typedef enum logic [1:0] {
        fetchState, executeState, memState, writebackState
    } state_e;

    typedef struct packed {
        aluOp_e aluOp;
        memOp_e memOp;
        branchOp_e branchOp;
        logic useImmediate;
        logic signExtend;
        logic writeReg;
        logic [4:0] writeIndex;
        logic link;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] shamt;
        logic [15:0] immediate;
        logic [25:0] target;
    } control_t;

    function automatic logic isLoad(memOp_e op);
        return op inside {memLb, memLbu, memLh, memLhu, memLw};
    endfunction

    function automatic logic isStore(memOp_e op);
        return op inside {memSb, memSh, memSw};
    endfunction

endpackage
